//--- ooo_core_top.f
src/ooo_core_pkg.sv
src/issue_if.sv
src/writeback_if.sv
src/instr_decoder.sv
src/exec_units.sv
src/reorder_buffer.sv
src/ooo_core_top.sv
verification/tb_clock_gen.sv
verification/tb_ooo_core.sv

//--- run_sim.sh
#!/bin/sh
# build and run the ooo core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ooo_core -Mdir obj_dir -f ooo_core_top.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_ooo_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- src/exec_units.sv
`timescale 1ns/1ps

module exec_units #(
    parameter int rob_depth  = 8,
    parameter int mul_stages = 3
) (
    input  logic       clk,
    input  logic       rst_n,
    issue_if.units     iss,
    writeback_if.units wb
);
    import ooo_core_pkg::*;

    localparam int tag_w = $clog2(rob_depth);

    logic       alu_start, mul_start;
    logic [4:0] shamt;
    xword_t     alu_res;

    logic [mul_stages-1:0] mul_vld;
    xword_t                mul_prod [mul_stages];
    logic [tag_w-1:0]      mul_tag  [mul_stages];

    assign alu_start = iss.valid && (iss.unit == unit_alu);
    assign mul_start = iss.valid && (iss.unit == unit_mul);
    assign shamt     = iss.op_b[4:0];

    always_comb begin
        case (iss.alu_op)
            add:     alu_res = iss.op_a + iss.op_b;
            sub:     alu_res = iss.op_a - iss.op_b;
            sll:     alu_res = iss.op_a << shamt;
            slt:     alu_res = xword_t'($signed(iss.op_a) < $signed(iss.op_b));
            sltu:    alu_res = xword_t'(iss.op_a < iss.op_b);
            xor_op:  alu_res = iss.op_a ^ iss.op_b;
            srl:     alu_res = iss.op_a >> shamt;
            sra:     alu_res = xword_t'($signed(iss.op_a) >>> shamt);
            or_op:   alu_res = iss.op_a | iss.op_b;
            and_op:  alu_res = iss.op_a & iss.op_b;
            pass_b:  alu_res = iss.op_b;
            default: alu_res = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb.alu_done <= 1'b0;
        end else begin
            wb.alu_done <= alu_start;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_start) begin
            wb.alu_tag  <= iss.tag;
            wb.alu_data <= alu_res;
        end
    end

    // multiply shift pipe, one new op per cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mul_vld <= '0;
        end else begin
            mul_vld[0] <= mul_start;
            for (int i = 1; i < mul_stages; i++) begin
                mul_vld[i] <= mul_vld[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mul_start) begin
            mul_prod[0] <= iss.op_a * iss.op_b; // low half only
            mul_tag[0]  <= iss.tag;
        end
        for (int i = 1; i < mul_stages; i++) begin
            mul_prod[i] <= mul_prod[i-1];
            mul_tag[i]  <= mul_tag[i-1];
        end
    end

    assign wb.mul_done = mul_vld[mul_stages-1];
    assign wb.mul_tag  = mul_tag[mul_stages-1];
    assign wb.mul_data = mul_prod[mul_stages-1];

endmodule

//--- src/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder #(
    parameter int rob_depth = 8
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         instr_valid,
    input  logic [31:0]                  instr,
    input  logic [$clog2(rob_depth)-1:0] alloc_tag,
    input  logic                         rob_full,
    input  logic                         commit_valid,
    input  logic [$clog2(rob_depth)-1:0] commit_tag,
    input  ooo_core_pkg::reg_idx_t       commit_rd,
    input  ooo_core_pkg::xword_t         commit_data,
    output logic                         issue_stall,
    issue_if.decoder                     iss
);
    import ooo_core_pkg::*;

    localparam int tag_w = $clog2(rob_depth);

    typedef enum logic [1:0] {src_reg, src_imm, src_upper} opb_sel_e;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rs1, rs2, rd_idx;
    xword_t     imm_i, imm_u;
    xword_t     rs1_val, rs2_val;

    logic     dec_ok, use_rs1, use_rs2, hazard, accept;
    unit_e    dec_unit;
    alu_op_e  dec_op;
    opb_sel_e opb_sel;

    xword_t           rf [1:31]; // x0 is hardwired
    logic [31:0]      pending;
    logic [tag_w-1:0] writer [32];

    function automatic alu_op_e base_op(input logic [2:0] f3);
        case (f3)
            3'b000:  return add;
            3'b001:  return sll;
            3'b010:  return slt;
            3'b011:  return sltu;
            3'b100:  return xor_op;
            3'b101:  return srl;
            3'b110:  return or_op;
            default: return and_op;
        endcase
    endfunction

    assign opcode = instr[6:0];
    assign rd_idx = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];
    assign imm_i  = {{20{instr[31]}}, instr[31:20]};
    assign imm_u  = {instr[31:12], 12'b0};

    always_comb begin
        dec_ok   = 1'b0;
        dec_unit = unit_alu;
        dec_op   = base_op(funct3);
        opb_sel  = src_reg;
        use_rs1  = 1'b0;
        use_rs2  = 1'b0;
        case (opcode)
            opc_op: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                if (funct7 == funct7_muldiv) begin
                    dec_unit = unit_mul;
                    dec_ok   = (funct3 == 3'b000); // only mul, no mulh/div
                end else if (funct7 == funct7_alt) begin
                    dec_op = (funct3 == 3'b000) ? sub : sra;
                    dec_ok = (funct3 == 3'b000) || (funct3 == 3'b101);
                end else begin
                    dec_ok = (funct7 == 7'b0);
                end
            end
            opc_op_imm: begin
                use_rs1 = 1'b1;
                opb_sel = src_imm;
                dec_ok  = 1'b1;
                if (funct3 == 3'b001) begin
                    dec_ok = (funct7 == 7'b0);
                end else if (funct3 == 3'b101) begin
                    dec_op = (funct7 == funct7_alt) ? sra : srl;
                    dec_ok = (funct7 == 7'b0) || (funct7 == funct7_alt);
                end
            end
            opc_lui: begin
                dec_ok  = 1'b1;
                dec_op  = pass_b;
                opb_sel = src_upper;
            end
            default: dec_ok = 1'b0; // dropped silently
        endcase
    end

    // wait for sources to be committed, no bypass network
    assign hazard = dec_ok && ((use_rs1 && pending[rs1]) || (use_rs2 && pending[rs2]));
    assign issue_stall = rob_full || (instr_valid && hazard);
    assign accept      = instr_valid && !issue_stall;

    assign rs1_val = (rs1 == '0) ? '0 : rf[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : rf[rs2];

    always_ff @(posedge clk) begin
        if (commit_valid && commit_rd != '0) begin
            rf[commit_rd] <= commit_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            if (commit_valid && writer[commit_rd] == commit_tag) begin
                pending[commit_rd] <= 1'b0;
            end
            // a new writer of the same register wins over the clear
            if (accept && dec_ok && rd_idx != '0) begin
                pending[rd_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && dec_ok && rd_idx != '0) begin
            writer[rd_idx] <= alloc_tag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            iss.valid <= 1'b0;
        end else begin
            iss.valid <= accept && dec_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            iss.unit   <= dec_unit;
            iss.alu_op <= dec_op;
            iss.op_a   <= rs1_val;
            iss.op_b   <= (opb_sel == src_reg) ? rs2_val :
                          (opb_sel == src_imm) ? imm_i : imm_u;
            iss.tag    <= alloc_tag;
            iss.rd     <= rd_idx;
        end
    end

endmodule

//--- src/issue_if.sv
`timescale 1ns/1ps

interface issue_if #(
    parameter int rob_depth = 8
);
    import ooo_core_pkg::*;

    localparam int tag_w = $clog2(rob_depth);

    logic             valid;  // one-cycle strobe per operation
    unit_e            unit;
    alu_op_e          alu_op;
    xword_t           op_a;
    xword_t           op_b;
    logic [tag_w-1:0] tag;
    reg_idx_t         rd;

    modport decoder (
        output valid, unit, alu_op, op_a, op_b, tag, rd
    );

    modport units (
        input valid, unit, alu_op, op_a, op_b, tag
    );

    // rob only needs enough to open an entry
    modport rob (
        input valid, tag, rd
    );

endinterface

//--- src/ooo_core_pkg.sv
package ooo_core_pkg;

    parameter int xlen = 32;

    typedef logic [4:0]      reg_idx_t;
    typedef logic [xlen-1:0] xword_t;

    // pass_b forwards operand b untouched, used by lui
    typedef enum logic [3:0] {
        add,
        sub,
        sll,
        slt,
        sltu,
        xor_op,
        srl,
        sra,
        or_op,
        and_op,
        pass_b
    } alu_op_e;

    typedef enum logic {
        unit_alu,
        unit_mul
    } unit_e;

    // RV32 major opcodes
    parameter logic [6:0] opc_op     = 7'b0110011;
    parameter logic [6:0] opc_op_imm = 7'b0010011;
    parameter logic [6:0] opc_lui    = 7'b0110111;

    parameter logic [6:0] funct7_alt    = 7'b0100000; // sub, sra, srai
    parameter logic [6:0] funct7_muldiv = 7'b0000001; // M extension

endpackage

//--- src/ooo_core_top.sv
`timescale 1ns/1ps

module ooo_core_top #(
    parameter int rob_depth  = 8,
    parameter int mul_stages = 3
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   instr_valid,
    input  logic [31:0]            instr,
    output logic                   issue_stall,
    output logic                   commit_valid,
    output ooo_core_pkg::reg_idx_t commit_rd,
    output ooo_core_pkg::xword_t   commit_data
);

    logic [$clog2(rob_depth)-1:0] alloc_tag;
    logic [$clog2(rob_depth)-1:0] commit_tag;
    logic                         rob_full;

    issue_if     #(.rob_depth(rob_depth)) u_iss ();
    writeback_if #(.rob_depth(rob_depth)) u_wb ();

    instr_decoder #(.rob_depth(rob_depth)) u_instr_decoder (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .alloc_tag    (alloc_tag),
        .rob_full     (rob_full),
        .commit_valid (commit_valid),
        .commit_tag   (commit_tag),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .issue_stall  (issue_stall),
        .iss          (u_iss.decoder)
    );

    exec_units #(
        .rob_depth  (rob_depth),
        .mul_stages (mul_stages)
    ) u_exec_units (
        .clk   (clk),
        .rst_n (rst_n),
        .iss   (u_iss.units),
        .wb    (u_wb.units)
    );

    reorder_buffer #(.rob_depth(rob_depth)) u_reorder_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .iss          (u_iss.rob),
        .wb           (u_wb.rob),
        .alloc_tag    (alloc_tag),
        .rob_full     (rob_full),
        .commit_valid (commit_valid),
        .commit_tag   (commit_tag),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data)
    );

endmodule

//--- src/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer #(
    parameter int rob_depth = 8
) (
    input  logic                         clk,
    input  logic                         rst_n,
    issue_if.rob                         iss,
    writeback_if.rob                     wb,
    output logic [$clog2(rob_depth)-1:0] alloc_tag,
    output logic                         rob_full,
    output logic                         commit_valid,
    output logic [$clog2(rob_depth)-1:0] commit_tag,
    output ooo_core_pkg::reg_idx_t       commit_rd,
    output ooo_core_pkg::xword_t         commit_data
);
    import ooo_core_pkg::*;

    localparam int tag_w = $clog2(rob_depth);
    localparam int cnt_w = tag_w + 1;

    logic [rob_depth-1:0] ent_done;
    reg_idx_t             ent_rd   [rob_depth];
    xword_t               ent_data [rob_depth];

    logic [tag_w-1:0] head, tail;
    logic [cnt_w-1:0] count;

    logic   alu_hit, mul_hit, retire;
    xword_t head_data;

    // the entry opened by a strobe in flight is already taken
    assign alloc_tag = tail + tag_w'(iss.valid);
    assign rob_full  = (int'(count) + int'(iss.valid)) >= rob_depth;

    // head may retire in the same cycle its result arrives
    assign alu_hit   = wb.alu_done && (wb.alu_tag == head);
    assign mul_hit   = wb.mul_done && (wb.mul_tag == head);
    assign retire    = (count != '0) && (ent_done[head] || alu_hit || mul_hit);
    assign head_data = alu_hit ? wb.alu_data :
                       mul_hit ? wb.mul_data : ent_data[head];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ent_done <= '0;
            head     <= '0;
            tail     <= '0;
            count    <= '0;
        end else begin
            if (wb.alu_done) ent_done[wb.alu_tag] <= 1'b1;
            if (wb.mul_done) ent_done[wb.mul_tag] <= 1'b1;
            if (iss.valid) begin
                ent_done[tail] <= 1'b0;
                tail           <= tail + 1'b1;
            end
            if (retire) begin
                ent_done[head] <= 1'b0;
                head           <= head + 1'b1;
            end
            count <= count + cnt_w'(iss.valid) - cnt_w'(retire);
        end
    end

    always_ff @(posedge clk) begin
        if (iss.valid) ent_rd[tail] <= iss.rd;
        if (wb.alu_done) ent_data[wb.alu_tag] <= wb.alu_data;
        if (wb.mul_done) ent_data[wb.mul_tag] <= wb.mul_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= retire;
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            commit_tag  <= head;
            commit_rd   <= ent_rd[head];
            commit_data <= head_data;
        end
    end

endmodule

//--- src/writeback_if.sv
`timescale 1ns/1ps

interface writeback_if #(
    parameter int rob_depth = 8
);
    import ooo_core_pkg::*;

    localparam int tag_w = $clog2(rob_depth);

    logic             alu_done;
    logic [tag_w-1:0] alu_tag;
    xword_t           alu_data;
    logic             mul_done; // may coincide with alu_done
    logic [tag_w-1:0] mul_tag;
    xword_t           mul_data;

    modport units (
        output alu_done, alu_tag, alu_data, mul_done, mul_tag, mul_data
    );

    modport rob (
        input alu_done, alu_tag, alu_data, mul_done, mul_tag, mul_data
    );

endinterface

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period_ns = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

endmodule

//--- verification/tb_ooo_core.sv
`timescale 1ns/1ps

module tb_ooo_core;

    localparam int rob_depth      = 8;
    localparam int mul_stages     = 3;
    localparam int max_instrs     = 400;
    localparam int timeout_cycles = max_instrs * (mul_stages + 6);

    localparam logic [6:0] opc_reg = 7'b0110011;
    localparam logic [6:0] opc_imm = 7'b0010011;
    localparam logic [6:0] opc_lui = 7'b0110111;
    localparam logic [6:0] f7_alt  = 7'b0100000;
    localparam logic [6:0] f7_mul  = 7'b0000001;

    logic        clk, rst_n, instr_valid, issue_stall, commit_valid;
    logic [31:0] instr, commit_data;
    logic [4:0]  commit_rd;

    logic [15:0] lfsr = 16'd52388;
    logic [31:0] model_rf [32];
    logic [36:0] exp_q [$]; // {rd, data} in acceptance order
    logic        exp_valid;
    logic [4:0]  exp_rd;
    logic [31:0] exp_data;
    logic        offered, in_burst, burst_stalled;
    int          cycles = 0;

    tb_clock_gen #(.period_ns(20)) u_clock_gen (.clk(clk));

    ooo_core_top #(
        .rob_depth  (rob_depth),
        .mul_stages (mul_stages)
    ) i_ooo_core_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .issue_stall  (issue_stall),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data)
    );

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    // fibonacci lfsr with taps 16 14 13 11
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [4:0] any_reg();
        return 5'(lfsr_bits(3));
    endfunction

    function automatic logic [4:0] nz_reg();
        return 5'(lfsr_bits(3) % 7 + 1);
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opc_reg};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, opc_imm};
    endfunction

    // shifts take a 5 bit shamt and srai sets the alt funct7
    function automatic logic [11:0] imm_for(input logic [2:0] f3, input logic alt);
        if (f3 == 3'b001 || f3 == 3'b101)
            return {(alt && f3 == 3'b101) ? f7_alt : 7'b0, 5'(lfsr_bits(5))};
        return 12'(lfsr_bits(12));
    endfunction

    function automatic logic [31:0] unsupported_instr();
        case (lfsr_bits(2))
            0:       return {25'(lfsr_bits(25)), 7'b0000011}; // load
            1:       return r_type(f7_mul, any_reg(), any_reg(), {2'(lfsr_bits(2)), 1'b1},
                               any_reg());
            2:       return r_type(7'b0000010, any_reg(), any_reg(), 3'(lfsr_bits(3)), any_reg());
            default: return {f7_alt, 5'(lfsr_bits(5)), any_reg(), 3'b001, any_reg(), opc_imm};
        endcase
    endfunction

    function automatic logic [31:0] random_instr();
        logic [2:0] f3;
        logic       alt;
        f3  = 3'(lfsr_bits(3));
        alt = lfsr_bits(1) != 0;
        case (lfsr_bits(3))
            0, 1, 2: return r_type((alt && (f3 == 3'b000 || f3 == 3'b101)) ? f7_alt : 7'b0,
                                   any_reg(), any_reg(), f3, any_reg());
            3, 4:    return i_type(imm_for(f3, alt), any_reg(), f3, any_reg());
            5:       return {20'(lfsr_bits(20)), any_reg(), opc_lui};
            6:       return r_type(f7_mul, any_reg(), any_reg(), 3'b000, any_reg());
            default: return unsupported_instr();
        endcase
    endfunction

    // RV32I plus mul with 0 returned for encodings the core drops
    function automatic logic model_exec(input logic [31:0] w, output logic [4:0] rd,
                                        output logic [31:0] res);
        logic [6:0]  opc, f7;
        logic [2:0]  f3;
        logic [31:0] a, b;
        logic        is_reg, alt, ok;
        opc    = w[6:0];
        f3     = w[14:12];
        f7     = w[31:25];
        rd     = w[11:7];
        is_reg = (opc == opc_reg);
        alt    = (f7 == f7_alt);
        a      = model_rf[w[19:15]];
        b      = is_reg ? model_rf[w[24:20]] : {{20{w[31]}}, w[31:20]};
        res    = '0;
        if (opc == opc_lui) begin
            res = {w[31:12], 12'b0};
            return 1'b1;
        end
        if (!is_reg && opc != opc_imm)
            return 1'b0;
        if (is_reg && f7 == f7_mul) begin
            res = a * b;
            return f3 == 3'b000;
        end
        ok = is_reg ? (f7 == 7'b0 || (alt && (f3 == 3'b000 || f3 == 3'b101))) :
             (f3 == 3'b001) ? (f7 == 7'b0) :
             (f3 == 3'b101) ? (f7 == 7'b0 || alt) : 1'b1;
        case (f3)
            3'b000:  res = (is_reg && alt) ? a - b : a + b;
            3'b001:  res = a << b[4:0];
            3'b010:  res = {31'b0, $signed(a) < $signed(b)};
            3'b011:  res = {31'b0, a < b};
            3'b100:  res = a ^ b;
            3'b101:  res = alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  res = a | b;
            default: res = a & b;
        endcase
        return ok;
    endfunction

    function automatic void update_head();
        exp_valid = (exp_q.size() != 0);
        if (exp_valid)
            {exp_rd, exp_data} = exp_q[0];
    endfunction

    function automatic void model_accept(input logic [31:0] w);
        logic [4:0]  rd;
        logic [31:0] res;
        if (model_exec(w, rd, res)) begin
            exp_q.push_back({rd, res});
            if (rd != 5'd0)
                model_rf[rd] = res;
        end
        update_head();
    endfunction

    // runs from a falling edge to the falling edge after acceptance
    task automatic offer_instr(input logic [31:0] w);
        logic stalled;
        instr_valid = 1'b1;
        instr       = w;
        offered     = 1'b1;
        stalled     = 1'b1;
        while (stalled) begin
            #1;
            stalled = issue_stall; // settled until the rising edge
            if (stalled && in_burst)
                burst_stalled = 1'b1;
            if (!stalled)
                model_accept(w);
            @(negedge clk);
        end
    endtask

    commit_expected: assert property (@(negedge clk) disable iff (!rst_n)
        commit_valid |-> exp_valid)
        else stop_on_error($sformatf("unexpected commit of x%0d at %0d ns, nothing outstanding",
                                     commit_rd, $time));

    commit_value: assert property (@(negedge clk) disable iff (!rst_n)
        (commit_valid && exp_valid) |-> (commit_rd == exp_rd && commit_data == exp_data))
        else stop_on_error($sformatf("mismatch at %0d ns: expected x%0d = %08h, got x%0d = %08h",
                                     $time, exp_rd, exp_data, commit_rd, commit_data));

    quiet_after_reset: assert property (@(negedge clk) disable iff (!rst_n)
        !offered |-> (!issue_stall && !commit_valid))
        else stop_on_error("issue_stall or commit_valid went high before any instruction");

    always @(negedge clk) begin
        if (rst_n && commit_valid) begin
            #2; // after the checks of this edge
            if (exp_valid) begin
                void'(exp_q.pop_front());
                update_head();
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > timeout_cycles)
            stop_on_error($sformatf("timeout: test did not finish within %0d cycles",
                                    timeout_cycles));
    end

    initial begin
        rst_n         = 1'b0;
        instr_valid   = 1'b0;
        instr         = '0;
        offered       = 1'b0;
        in_burst      = 1'b0;
        burst_stalled = 1'b0;
        exp_valid     = 1'b0;
        exp_rd        = '0;
        exp_data      = '0;
        for (int i = 0; i < 32; i++)
            model_rf[i] = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (3) @(negedge clk);

        // load x1..x7 where each addi reads the lui just before it
        for (int r = 1; r < 8; r++) begin
            offer_instr({20'(lfsr_bits(20)), 5'(r), opc_lui});
            offer_instr(i_type(12'(lfsr_bits(12)), 5'(r), 3'b000, 5'(r)));
        end

        repeat (2) begin
            for (int f = 0; f < 8; f++) begin
                offer_instr(r_type(7'b0, nz_reg(), nz_reg(), 3'(f), nz_reg()));
                offer_instr(i_type(imm_for(3'(f), 1'b0), nz_reg(), 3'(f), nz_reg()));
            end
            offer_instr(r_type(f7_alt, nz_reg(), nz_reg(), 3'b000, nz_reg()));
            offer_instr(r_type(f7_alt, nz_reg(), nz_reg(), 3'b101, nz_reg()));
            offer_instr(i_type(imm_for(3'b101, 1'b1), nz_reg(), 3'b101, nz_reg()));
        end

        // alu ops on x1..x4 finish before the multiply into x7
        repeat (5) begin
            offer_instr(r_type(f7_mul, 5'd5, 5'd6, 3'b000, 5'd7));
            repeat (3)
                offer_instr(r_type(7'b0, 5'(lfsr_bits(2)) + 5'd1, 5'(lfsr_bits(2)) + 5'd1,
                                   3'(lfsr_bits(3)), 5'(lfsr_bits(2)) + 5'd1));
        end

        in_burst = 1'b1;
        offer_instr(r_type(f7_mul, 5'd2, 5'd1, 3'b000, 5'd3));
        offer_instr(r_type(f7_mul, 5'd3, 5'd3, 3'b000, 5'd4)); // waits for x3
        repeat (22)
            offer_instr(r_type(f7_mul, any_reg(), any_reg(), 3'b000, any_reg()));
        in_burst = 1'b0;

        offer_instr({25'(lfsr_bits(25)), 7'b0000011});
        offer_instr(r_type(f7_mul, 5'd1, 5'd2, 3'b100, 5'd3)); // div
        offer_instr(i_type(12'h401, 5'd1, 3'b001, 5'd2));
        offer_instr(r_type(f7_alt, 5'd1, 5'd2, 3'b111, 5'd3));
        offer_instr(i_type(12'h005, 5'd1, 3'b000, 5'd0));
        offer_instr(r_type(f7_mul, 5'd1, 5'd2, 3'b000, 5'd0));
        offer_instr({20'habcde, 5'd0, opc_lui});
        offer_instr(r_type(7'b0, 5'd1, 5'd0, 3'b000, 5'd5)); // x0 reads as zero
        offer_instr(i_type(12'h07b, 5'd0, 3'b110, 5'd6));

        repeat (240)
            offer_instr(random_instr());

        instr_valid = 1'b0;
        while (exp_valid)
            @(negedge clk);
        repeat (mul_stages + 4) @(negedge clk); // room for a stray commit
        if (burst_stalled) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            stop_on_error("issue_stall never went high during the multiply burst");
        end
    end

endmodule
